//--- cpuPkg.sv
package cpuPkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------
  localparam int dataWidth = 8;
  localparam int addrWidth = 16;
  localparam int uPcWidth  = 8;
  localparam int cmdWidth  = 4;
  localparam int endWidth  = 2;
  localparam int selWidth  = 4;

  // Low bit of each microinstruction field
  localparam int uopSrc   = 0;
  localparam int uopCmd   = uopSrc + selWidth;
  localparam int uopEnd   = uopCmd + cmdWidth;
  localparam int uopIncPc = uopEnd + endWidth;
  localparam int uopWidth = uopIncPc + 1;

  localparam logic [endWidth-1:0] endNone       = 2'd0;
  localparam logic [endWidth-1:0] endAlways     = 2'd1;
  localparam logic [endWidth-1:0] endIfNotTaken = 2'd2;

  // --------------------------------------------------
  // Micro-commands
  // --------------------------------------------------
  localparam logic [cmdWidth-1:0] cmdNop       = 4'd0;
  localparam logic [cmdWidth-1:0] cmdSetAddr   = 4'd1;
  localparam logic [cmdWidth-1:0] cmdStoreMem  = 4'd2;
  localparam logic [cmdWidth-1:0] cmdWriteMem  = 4'd3;
  localparam logic [cmdWidth-1:0] cmdZ80Op     = 4'd4;
  localparam logic [cmdWidth-1:0] cmdIncDec    = 4'd5;
  localparam logic [cmdWidth-1:0] cmdLoadX16Lo = 4'd6;
  localparam logic [cmdWidth-1:0] cmdLoadX16Hi = 4'd7;
  localparam logic [cmdWidth-1:0] cmdSetPc     = 4'd8;
  localparam logic [cmdWidth-1:0] cmdCopyX16   = 4'd9;
  localparam logic [cmdWidth-1:0] cmdHalt      = 4'd10;

  // Byte codes follow the opcode r field
  localparam logic [selWidth-1:0] regB   = 4'd0;
  localparam logic [selWidth-1:0] regC   = 4'd1;
  localparam logic [selWidth-1:0] regD   = 4'd2;
  localparam logic [selWidth-1:0] regE   = 4'd3;
  localparam logic [selWidth-1:0] regH   = 4'd4;
  localparam logic [selWidth-1:0] regL   = 4'd5;
  localparam logic [selWidth-1:0] regHl  = 4'd6;
  localparam logic [selWidth-1:0] regA   = 4'd7;
  localparam logic [selWidth-1:0] regPc  = 4'd8;
  localparam logic [selWidth-1:0] regX16 = 4'd9;

  localparam int flagZ = 7;
  localparam int flagN = 6;
  localparam int flagH = 5;
  localparam int flagC = 4;
  localparam logic [dataWidth-1:0] flagsReset = 8'hB0;

  // --------------------------------------------------
  // Opcodes
  // --------------------------------------------------
  localparam logic [dataWidth-1:0] opNop    = 8'h00;
  localparam logic [dataWidth-1:0] opHalt   = 8'h76;
  localparam logic [dataWidth-1:0] opJp     = 8'hC3;
  localparam logic [dataWidth-1:0] opJpZ    = 8'hCA;
  localparam logic [dataWidth-1:0] opJpNz   = 8'hC2;
  localparam logic [dataWidth-1:0] opJpC    = 8'hDA;
  localparam logic [dataWidth-1:0] opJpNc   = 8'hD2;
  localparam logic [dataWidth-1:0] opLdHlNn = 8'h21;
  localparam logic [dataWidth-1:0] opLdAHl  = 8'h7E;
  localparam logic [dataWidth-1:0] opLdHlA  = 8'h77;

  localparam logic [2:0] aluAdd = 3'b000;
  localparam logic [2:0] aluSub = 3'b010;
  localparam logic [2:0] aluAnd = 3'b100;
  localparam logic [2:0] aluXor = 3'b101;
  localparam logic [2:0] aluOr  = 3'b110;

  // One-hot sequencer states
  localparam logic [3:0] stAfterReset = 4'b0001;
  localparam logic [3:0] stStart      = 4'b0010;
  localparam logic [3:0] stRun        = 4'b0100;
  localparam logic [3:0] stEnd        = 4'b1000;

  // First micro address of each flow
  localparam logic [uPcWidth-1:0] flowFetch  = 8'd0;
  localparam logic [uPcWidth-1:0] flowLdImm  = 8'd1;
  localparam logic [uPcWidth-1:0] flowZ80Op  = 8'd3;
  localparam logic [uPcWidth-1:0] flowIncDec = 8'd4;
  localparam logic [uPcWidth-1:0] flowLdHlNn = 8'd5;
  localparam logic [uPcWidth-1:0] flowJp     = 8'd10;
  localparam logic [uPcWidth-1:0] flowLdAHl  = 8'd15;
  localparam logic [uPcWidth-1:0] flowLdHlA  = 8'd17;
  localparam logic [uPcWidth-1:0] flowHalt   = 8'd19;

  typedef union packed {
    struct packed {
      logic [1:0] group;
      logic [2:0] dst;
      logic [2:0] src;
    } moveView;
    struct packed {
      logic [4:0] aluOp;
      logic [2:0] src;
    } aluView;
  } opcodeT;

endpackage

//--- uopIf.sv
interface uopIf import cpuPkg::*; (input logic iClock, input logic rstN);

  logic [cmdWidth-1:0] cmd;
  logic [selWidth-1:0] src;
  logic [endWidth-1:0] endCtl;
  logic                incPc;
  opcodeT              opcode;   // Instruction byte of the running flow
  logic                taken;    // Branch condition of that byte

  modport sequencer (
    output cmd, src, endCtl, incPc, opcode,
    input  taken
  );

  modport execute (
    input  iClock, rstN, cmd, src, endCtl, incPc, opcode,
    output taken
  );

endinterface

//--- regIf.sv
interface regIf import cpuPkg::*; ();

  logic [selWidth-1:0]  readSel;
  logic [addrWidth-1:0] readData;
  logic [selWidth-1:0]  writeSel;
  logic                 writeEn;
  logic [addrWidth-1:0] writeData;
  logic                 pcLoad;     // PC from X16
  logic                 pcInc;
  logic                 flagsWe;
  logic [dataWidth-1:0] flagsNext;
  logic                 addrLatch;  // Capture readSel as memory address source
  logic [dataWidth-1:0] a;
  logic [addrWidth-1:0] x16;
  logic [dataWidth-1:0] flags;

  modport execute (
    output readSel, writeSel, writeEn, writeData, pcLoad, pcInc,
    output flagsWe, flagsNext, addrLatch,
    input  readData, a, x16, flags
  );

  modport register (
    input  readSel, writeSel, writeEn, writeData, pcLoad, pcInc,
    input  flagsWe, flagsNext, addrLatch,
    output readData, a, x16, flags
  );

endinterface

//--- microcodeRom.sv
module microcodeRom
  import cpuPkg::*;
(
  input  logic [uPcWidth-1:0] uPc,
  input  opcodeT              opcode,
  output logic [uopWidth-1:0] uop,
  output logic [uPcWidth-1:0] flowStart
);

  function automatic logic [uopWidth-1:0] step(
    input logic                inc,
    input logic [endWidth-1:0] endCtl,
    input logic [cmdWidth-1:0] cmd,
    input logic [selWidth-1:0] src
  );
    return {inc, endCtl, cmd, src};
  endfunction

  // --------------------------------------------------
  // Micro-program
  // --------------------------------------------------
  always_comb
  begin
    case (uPc)
      flowFetch:      uop = step(1'b1, endAlways, cmdSetAddr, regPc);
      flowLdImm:      uop = step(1'b1, endNone, cmdSetAddr, regPc);
      flowLdImm + 1:  uop = step(1'b0, endAlways, cmdStoreMem, regPc);
      flowZ80Op:      uop = step(1'b0, endAlways, cmdZ80Op, regPc);
      flowIncDec:     uop = step(1'b0, endAlways, cmdIncDec, regPc);
      flowLdHlNn:     uop = step(1'b1, endNone, cmdSetAddr, regPc);
      flowLdHlNn + 1: uop = step(1'b0, endNone, cmdLoadX16Lo, regX16);
      flowLdHlNn + 2: uop = step(1'b1, endNone, cmdSetAddr, regPc);
      flowLdHlNn + 3: uop = step(1'b0, endNone, cmdLoadX16Hi, regX16);
      flowLdHlNn + 4: uop = step(1'b0, endAlways, cmdCopyX16, regHl);
      flowJp:         uop = step(1'b1, endNone, cmdSetAddr, regPc);
      flowJp + 1:     uop = step(1'b0, endNone, cmdLoadX16Lo, regX16);
      flowJp + 2:     uop = step(1'b1, endNone, cmdSetAddr, regPc);
      flowJp + 3:     uop = step(1'b0, endIfNotTaken, cmdLoadX16Hi, regX16);
      flowJp + 4:     uop = step(1'b0, endAlways, cmdSetPc, regX16);
      flowLdAHl:      uop = step(1'b0, endNone, cmdSetAddr, regHl);
      flowLdAHl + 1:  uop = step(1'b0, endAlways, cmdStoreMem, regA);
      flowLdHlA:      uop = step(1'b0, endNone, cmdSetAddr, regHl);
      flowLdHlA + 1:  uop = step(1'b0, endAlways, cmdWriteMem, regA);
      flowHalt:       uop = step(1'b0, endNone, cmdHalt, regPc);  // Parks here
      default:        uop = step(1'b0, endAlways, cmdNop, regPc);
    endcase
  end

  // Opcode to flow lookup where anything unknown just fetches again
  always_comb
  begin
    flowStart = flowFetch;
    case (opcode.moveView.group)
      2'b00:
        if (opcode.moveView.dst != 3'b110)
        begin
          if (opcode.moveView.src == 3'b110)
            flowStart = flowLdImm;                  // LD r,n
          else if (opcode.moveView.src[2:1] == 2'b10)
            flowStart = flowIncDec;                 // INC r / DEC r
        end
      2'b01:
        if (opcode.moveView.dst != 3'b110 && opcode.moveView.src != 3'b110)
          flowStart = flowZ80Op;
      2'b10:
        if (opcode.aluView.src != 3'b110 &&
            opcode.aluView.aluOp[2:0] inside {aluAdd, aluSub, aluAnd, aluXor, aluOr})
          flowStart = flowZ80Op;
      default: ;
    endcase
    case (opcode)
      opLdHlNn:                            flowStart = flowLdHlNn;
      opLdAHl:                             flowStart = flowLdAHl;
      opLdHlA:                             flowStart = flowLdHlA;
      opHalt:                              flowStart = flowHalt;
      opJp, opJpZ, opJpNz, opJpC, opJpNc:  flowStart = flowJp;
      default: ;
    endcase
  end

endmodule

//--- microSequencer.sv
module microSequencer
  import cpuPkg::*;
(
  input logic                 iClock,
  input logic                 rstN,
  input logic [dataWidth-1:0] memReadData,
  uopIf.sequencer             uop
);

  logic [3:0]          state;
  logic [3:0]          nextState;
  logic [uPcWidth-1:0] uPc;
  logic [uPcWidth-1:0] flowStart;
  logic [uopWidth-1:0] romWord;
  opcodeT              opcodeQ;
  logic                flowRun;
  logic                flowEnd;
  logic                holding;

  microcodeRom rom_i (
    .uPc       (uPc),
    .opcode    (opcodeQ),
    .uop       (romWord),
    .flowStart (flowStart)
  );

  assign flowRun = state == stRun;

  // A bubble goes out whenever the flow is not running
  assign uop.cmd    = flowRun ? romWord[uopCmd +: cmdWidth] : cmdNop;
  assign uop.src    = romWord[uopSrc +: selWidth];
  assign uop.endCtl = flowRun ? romWord[uopEnd +: endWidth] : endNone;
  assign uop.incPc  = flowRun & romWord[uopIncPc];
  assign uop.opcode = opcodeQ;

  assign flowEnd = (uop.endCtl == endAlways) || (uop.endCtl == endIfNotTaken && !uop.taken);
  assign holding = uop.cmd == cmdHalt;   // Halt step never advances

  // --------------------------------------------------
  // Flow FSM
  // --------------------------------------------------
  always_comb
  begin
    case (state)
      stAfterReset: nextState = stStart;
      stStart:      nextState = stRun;
      stRun:        nextState = flowEnd ? stEnd : stRun;
      stEnd:        nextState = stStart;
      default:      nextState = stAfterReset;
    endcase
  end

  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      state   <= stAfterReset;
      uPc     <= flowFetch;
      opcodeQ <= opNop;   // NOP decodes to fetch, so the core starts fetching
    end
    else
    begin
      state <= nextState;
      if (state == stStart)
        uPc <= (uPc == flowFetch) ? flowStart : flowFetch;  // Alternate fetch and execute
      else if (flowRun && !flowEnd && !holding)
        uPc <= uPc + 1'b1;
      if (state == stEnd && uPc == flowFetch)
        opcodeQ <= memReadData;
    end
  end

  assert property (@(posedge iClock) disable iff (!rstN) $onehot(state));

  // Once the halt step is reached the flow never leaves it
  assert property (@(posedge iClock) disable iff (!rstN)
    flowRun && holding |=> flowRun && holding);

endmodule

//--- registerFile.sv
module registerFile
  import cpuPkg::*;
(
  input  logic                 iClock,
  input  logic                 rstN,
  regIf.register               regs,
  output logic [addrWidth-1:0] memAddr
);

  logic [dataWidth-1:0] bReg;
  logic [dataWidth-1:0] cReg;
  logic [dataWidth-1:0] dReg;
  logic [dataWidth-1:0] eReg;
  logic [dataWidth-1:0] hReg;
  logic [dataWidth-1:0] lReg;
  logic [dataWidth-1:0] aReg;
  logic [addrWidth-1:0] x16Reg;
  logic [addrWidth-1:0] pcReg;
  logic [dataWidth-1:0] flagsReg;
  logic [selWidth-1:0]  addrSel;
  logic [selWidth-1:0]  addrSelNow;

  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      bReg   <= '0;
      cReg   <= '0;
      dReg   <= '0;
      eReg   <= '0;
      hReg   <= '0;
      lReg   <= '0;
      aReg   <= '0;
      x16Reg <= '0;
    end
    else if (regs.writeEn)
    begin
      case (regs.writeSel)
        regB:   bReg <= regs.writeData[dataWidth-1:0];
        regC:   cReg <= regs.writeData[dataWidth-1:0];
        regD:   dReg <= regs.writeData[dataWidth-1:0];
        regE:   eReg <= regs.writeData[dataWidth-1:0];
        regH:   hReg <= regs.writeData[dataWidth-1:0];
        regL:   lReg <= regs.writeData[dataWidth-1:0];
        regHl:
        begin
          hReg <= regs.writeData[addrWidth-1:dataWidth];
          lReg <= regs.writeData[dataWidth-1:0];
        end
        regA:   aReg <= regs.writeData[dataWidth-1:0];
        regX16: x16Reg <= regs.writeData;
        default: ;
      endcase
    end
  end

  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      pcReg    <= '0;
      flagsReg <= flagsReset;
      addrSel  <= regPc;
    end
    else
    begin
      if (regs.pcLoad)
        pcReg <= x16Reg;        // Jump target
      else if (regs.pcInc)
        pcReg <= pcReg + 1'b1;
      if (regs.flagsWe)
        flagsReg <= regs.flagsNext;
      if (regs.addrLatch)
        addrSel <= regs.readSel;
    end
  end

  // --------------------------------------------------
  // Read side
  // --------------------------------------------------
  always_comb
  begin
    case (regs.readSel)
      regB:    regs.readData = {8'h00, bReg};
      regC:    regs.readData = {8'h00, cReg};
      regD:    regs.readData = {8'h00, dReg};
      regE:    regs.readData = {8'h00, eReg};
      regH:    regs.readData = {8'h00, hReg};
      regL:    regs.readData = {8'h00, lReg};
      regHl:   regs.readData = {hReg, lReg};
      regA:    regs.readData = {8'h00, aReg};
      regPc:   regs.readData = pcReg;
      regX16:  regs.readData = x16Reg;
      default: regs.readData = '0;
    endcase
  end

  assign regs.a     = aReg;
  assign regs.x16   = x16Reg;
  assign regs.flags = flagsReg;

  // New source shows on the bus in the same cycle as the read
  assign addrSelNow = regs.addrLatch ? regs.readSel : addrSel;

  always_comb
  begin
    case (addrSelNow)
      regHl:   memAddr = {hReg, lReg};
      regX16:  memAddr = x16Reg;
      default: memAddr = pcReg;
    endcase
  end

  // Execute side must only target real registers
  assert property (@(posedge iClock) disable iff (!rstN)
    regs.writeEn |-> (regs.writeSel <= regA || regs.writeSel == regX16));

endmodule

//--- executeUnit.sv
module executeUnit
  import cpuPkg::*;
(
  uopIf.execute                uop,
  regIf.execute                regs,
  input  logic [dataWidth-1:0] memReadData,
  output logic                 memRead,
  output logic                 memWrite,
  output logic [dataWidth-1:0] memWriteData,
  output logic                 halted
);

  opcodeT               op;
  logic [dataWidth-1:0] operand;
  logic [dataWidth-1:0] aluResult;
  logic [dataWidth-1:0] stepResult;
  logic [dataWidth:0]   sum;
  logic [dataWidth:0]   diff;
  logic [4:0]           halfSum;
  logic [4:0]           halfDiff;
  logic                 isAlu;
  logic                 isDec;

  assign op         = uop.opcode;
  assign operand    = regs.readData[dataWidth-1:0];
  assign isAlu      = op.aluView.aluOp[4:3] == 2'b10;
  assign isDec      = op.moveView.src[0];   // 100 INC, 101 DEC
  assign sum        = {1'b0, regs.a} + {1'b0, operand};
  assign diff       = {1'b0, regs.a} - {1'b0, operand};
  assign halfSum    = {1'b0, regs.a[3:0]} + {1'b0, operand[3:0]};
  assign halfDiff   = {1'b0, regs.a[3:0]} - {1'b0, operand[3:0]};
  assign stepResult = isDec ? operand - 1'b1 : operand + 1'b1;

  always_comb
  begin
    case (op.aluView.aluOp[2:0])
      aluAdd:  aluResult = sum[dataWidth-1:0];
      aluSub:  aluResult = diff[dataWidth-1:0];
      aluAnd:  aluResult = regs.a & operand;
      aluXor:  aluResult = regs.a ^ operand;
      default: aluResult = regs.a | operand;
    endcase
  end

  // --------------------------------------------------
  // Command decode
  // --------------------------------------------------
  always_comb
  begin
    regs.readSel   = uop.src;
    regs.writeSel  = uop.src;
    regs.writeEn   = 1'b0;
    regs.writeData = '0;
    regs.pcLoad    = 1'b0;
    regs.flagsWe   = 1'b0;
    regs.addrLatch = 1'b0;
    memRead        = 1'b0;
    memWrite       = 1'b0;
    case (uop.cmd)
      cmdSetAddr:
      begin
        regs.addrLatch = 1'b1;
        memRead        = 1'b1;
      end
      cmdStoreMem:
      begin
        regs.writeSel  = {1'b0, op.moveView.dst};  // LD r,n and LD A,(HL)
        regs.writeEn   = 1'b1;
        regs.writeData = {8'h00, memReadData};
      end
      cmdWriteMem: memWrite = 1'b1;
      cmdZ80Op:
      begin
        regs.readSel   = {1'b0, op.moveView.src};
        regs.writeSel  = isAlu ? regA : {1'b0, op.moveView.dst};
        regs.writeEn   = 1'b1;
        regs.writeData = {8'h00, isAlu ? aluResult : operand};
        regs.flagsWe   = isAlu;
      end
      cmdIncDec:
      begin
        regs.readSel   = {1'b0, op.moveView.dst};
        regs.writeSel  = {1'b0, op.moveView.dst};
        regs.writeEn   = 1'b1;
        regs.writeData = {8'h00, stepResult};
        regs.flagsWe   = 1'b1;
      end
      cmdLoadX16Lo:
      begin
        regs.writeSel  = regX16;
        regs.writeEn   = 1'b1;
        regs.writeData = {regs.x16[addrWidth-1:dataWidth], memReadData};
      end
      cmdLoadX16Hi:
      begin
        regs.writeSel  = regX16;
        regs.writeEn   = 1'b1;
        regs.writeData = {memReadData, regs.x16[dataWidth-1:0]};
      end
      cmdSetPc: regs.pcLoad = 1'b1;
      cmdCopyX16:
      begin
        regs.writeSel  = regHl;
        regs.writeEn   = 1'b1;
        regs.writeData = regs.x16;
      end
      default: ;
    endcase
  end

  assign regs.pcInc   = uop.incPc;
  assign memWriteData = operand;

  // --------------------------------------------------
  // Flags and branch condition
  // --------------------------------------------------
  always_comb
  begin
    regs.flagsNext = regs.flags & 8'hF0;
    if (uop.cmd == cmdIncDec)
    begin
      regs.flagsNext[flagZ] = stepResult == '0;
      regs.flagsNext[flagN] = isDec;
      regs.flagsNext[flagH] = isDec ? stepResult[3:0] == 4'hF : stepResult[3:0] == 4'h0;
    end
    else
    begin
      regs.flagsNext[flagZ] = aluResult == '0;
      regs.flagsNext[flagN] = op.aluView.aluOp[2:0] == aluSub;
      regs.flagsNext[flagH] = 1'b0;
      regs.flagsNext[flagC] = 1'b0;
      case (op.aluView.aluOp[2:0])
        aluAdd:
        begin
          regs.flagsNext[flagH] = halfSum[4];     // Carry out of bit 3
          regs.flagsNext[flagC] = sum[dataWidth];
        end
        aluSub:
        begin
          regs.flagsNext[flagH] = halfDiff[4];    // Borrow from bit 4
          regs.flagsNext[flagC] = diff[dataWidth];
        end
        aluAnd:  regs.flagsNext[flagH] = 1'b1;
        default: ;
      endcase
    end
  end

  always_comb
  begin
    case (op)
      opJp:    uop.taken = 1'b1;
      opJpZ:   uop.taken = regs.flags[flagZ];
      opJpNz:  uop.taken = !regs.flags[flagZ];
      opJpC:   uop.taken = regs.flags[flagC];
      opJpNc:  uop.taken = !regs.flags[flagC];
      default: uop.taken = 1'b0;
    endcase
  end

  always_ff @(posedge uop.iClock or negedge uop.rstN)
  begin
    if (!uop.rstN)
      halted <= 1'b0;
    else if (uop.cmd == cmdHalt)
      halted <= 1'b1;
  end

  assert property (@(posedge uop.iClock) disable iff (!uop.rstN) !(memRead && memWrite));

  // A halted core keeps the bus quiet
  assert property (@(posedge uop.iClock) disable iff (!uop.rstN)
    halted |-> !memRead && !memWrite);

endmodule

//--- dzCore.sv
module dzCore
  import cpuPkg::*;
(
  input  logic                 iClock,
  input  logic                 rstN,
  output logic [addrWidth-1:0] memAddr,
  output logic                 memRead,
  output logic                 memWrite,
  output logic [dataWidth-1:0] memWriteData,
  input  logic [dataWidth-1:0] memReadData,
  output logic                 halted
);

  uopIf uopBus (.iClock(iClock), .rstN(rstN));
  regIf regBus ();

  microSequencer sequencer_i (
    .iClock      (iClock),
    .rstN        (rstN),
    .memReadData (memReadData),
    .uop         (uopBus.sequencer)
  );

  executeUnit execute_i (
    .uop          (uopBus.execute),
    .regs         (regBus.execute),
    .memReadData  (memReadData),
    .memRead      (memRead),
    .memWrite     (memWrite),
    .memWriteData (memWriteData),
    .halted       (halted)
  );

  registerFile registers_i (
    .iClock  (iClock),
    .rstN    (rstN),
    .regs    (regBus.register),
    .memAddr (memAddr)
  );

endmodule

//--- tbCore.sv
module tbCore
  import cpuPkg::*;
();

  localparam int clockPeriod  = 40;
  localparam int resetCycles  = 5;
  localparam int cycleLimit   = 2000;   // Clock cycles allowed per test
  localparam int numTests     = 5;
  localparam int watchdogTime = numTests * (cycleLimit + 40) * clockPeriod;
  localparam logic [addrWidth-1:0] resultBase = 16'h8000;
  localparam logic [dataWidth-1:0] marker     = 8'hC5;

  logic                 iClock;
  logic                 rstN;
  logic [addrWidth-1:0] memAddr;
  logic                 memRead;
  logic                 memWrite;
  logic [dataWidth-1:0] memWriteData;
  logic [dataWidth-1:0] memReadData;
  logic                 halted;

  logic [dataWidth-1:0] mem [0:65535];
  logic [addrWidth-1:0] logAddr [$];    // Every write seen on the bus
  logic [dataWidth-1:0] logData [$];
  logic [addrWidth-1:0] expAddr [$];    // Writes the test predicts
  logic [dataWidth-1:0] expData [$];
  logic [addrWidth-1:0] here;           // Assembly pointer
  int                   lateAccesses;
  int                   errorCount;
  int                   passCount;
  int                   failCount;

  dzCore dut_i (
    .iClock       (iClock),
    .rstN         (rstN),
    .memAddr      (memAddr),
    .memRead      (memRead),
    .memWrite     (memWrite),
    .memWriteData (memWriteData),
    .memReadData  (memReadData),
    .halted       (halted)
  );

  initial
  begin
    iClock = 1'b0;
    forever #(clockPeriod / 2) iClock = ~iClock;
  end

  // --------------------------------------------------
  // Memory model with data one cycle after a read
  // --------------------------------------------------
  always @(posedge iClock)
  begin
    if (memRead)
      memReadData <= mem[memAddr];
    if (memWrite)
    begin
      mem[memAddr] = memWriteData;
      logAddr.push_back(memAddr);
      logData.push_back(memWriteData);
    end
    if (halted && (memRead || memWrite))
      lateAccesses = lateAccesses + 1;
  end

  initial
  begin
    #(watchdogTime);
    $display("Watchdog expired, the run hung");
    $display("Regression failed");
    $finish;
  end

  task automatic checkValue(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp)
    begin
      $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
      errorCount++;
    end
  endtask

  task automatic clearMemory();
    for (int i = 0; i < 65536; i++)
      mem[i] = i[15:8] ^ i[7:0] ^ 8'h5A;
    logAddr.delete();
    logData.delete();
    expAddr.delete();
    expData.delete();
    lateAccesses = 0;
    here = '0;
  endtask

  // --------------------------------------------------
  // Tiny assembler
  // --------------------------------------------------
  task automatic putByte(input logic [7:0] b);
    mem[here] = b;
    here = here + 16'd1;
  endtask

  task automatic putWord(input logic [15:0] w);
    putByte(w[7:0]);   // Little endian
    putByte(w[15:8]);
  endtask

  task automatic loadImm(input logic [3:0] r, input logic [7:0] n);
    putByte({2'b00, r[2:0], 3'b110});
    putByte(n);
  endtask

  task automatic moveReg(input logic [3:0] dst, input logic [3:0] src);
    putByte({2'b01, dst[2:0], src[2:0]});
  endtask

  task automatic aluWithReg(input logic [2:0] op, input logic [3:0] src);
    putByte({2'b10, op, src[2:0]});
  endtask

  task automatic stepReg(input logic [3:0] r, input logic dec);
    putByte({2'b00, r[2:0], 2'b10, dec});  // INC r or DEC r
  endtask

  task automatic loadHl(input logic [15:0] nn);
    putByte(opLdHlNn);
    putByte(nn[7:0]);
    putByte(nn[15:8]);
  endtask

  task automatic jumpTo(input logic [7:0] opc, input logic [15:0] target);
    putByte(opc);
    putWord(target);
  endtask

  // Side block at another address that stores the marker, then jumps back
  task automatic markerBranch(input logic [15:0] at, input logic [15:0] dest);
    logic [15:0] resume;
    resume = here;
    here = at;
    loadImm(regA, marker);
    loadHl(dest);
    putByte(opLdHlA);
    jumpTo(opJp, resume);
    here = resume;
  endtask

  task automatic expectStore(input logic [15:0] addr, input logic [7:0] data);
    expAddr.push_back(addr);
    expData.push_back(data);
  endtask

  task automatic runProgram();
    int cycles;
    @(posedge iClock);
    rstN <= 1'b0;
    repeat (resetCycles) @(posedge iClock);
    rstN <= 1'b1;
    cycles = 0;
    while (!halted && cycles < cycleLimit)
    begin
      @(posedge iClock);
      cycles++;
    end
    if (!halted)
    begin
      $display("Core did not halt within %0d cycles", cycleLimit);
      errorCount++;
    end
  endtask

  task automatic compareWrites();
    checkValue("write count", 16'(logAddr.size()), 16'(expAddr.size()));
    for (int i = 0; i < expAddr.size(); i++)
    begin
      if (i >= logAddr.size())
      begin
        $display("Write of 0x%h to 0x%h never happened", expData[i], expAddr[i]);
        errorCount++;
      end
      else
      begin
        checkValue("memAddr", logAddr[i], expAddr[i]);
        checkValue("memWriteData", {8'h00, logData[i]}, {8'h00, expData[i]});
      end
    end
  endtask

  task automatic reportTest(input string name, input int errorsBefore);
    if (errorCount == errorsBefore)
    begin
      $display("%s: pass", name);
      passCount++;
    end
    else
    begin
      $display("%s: FAIL", name);
      failCount++;
    end
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic loadStoreTest();
    int          errorsBefore;
    logic [7:0]  n;
    logic [15:0] nn;
    errorsBefore = errorCount;
    n  = 8'($urandom);
    nn = 16'h4000 | 16'($urandom_range(16'h3FFF));
    clearMemory();
    loadImm(regA, n);
    moveReg(regB, regA);    // Walk the byte through every register
    moveReg(regC, regB);
    moveReg(regD, regC);
    moveReg(regE, regD);
    moveReg(regH, regE);
    moveReg(regL, regH);
    loadImm(regA, 8'h00);
    moveReg(regA, regL);
    loadHl(nn);
    putByte(opLdHlA);
    putByte(opHalt);
    expectStore(nn, n);
    runProgram();
    compareWrites();
    reportTest("load and store", errorsBefore);
  endtask

  task automatic logicTest();
    int         errorsBefore;
    logic [7:0] a;
    logic [7:0] b;
    logic [2:0] ops [3];
    errorsBefore = errorCount;
    a = 8'($urandom);
    b = 8'($urandom);
    ops = '{aluAnd, aluOr, aluXor};
    clearMemory();
    loadImm(regB, b);
    for (int i = 0; i < 3; i++)
    begin
      loadImm(regA, a);
      aluWithReg(ops[i], regB);
      loadHl(resultBase + 16'(i));
      putByte(opLdHlA);
    end
    putByte(opHalt);
    expectStore(resultBase, a & b);
    expectStore(resultBase + 16'd1, a | b);
    expectStore(resultBase + 16'd2, a ^ b);
    runProgram();
    compareWrites();
    reportTest("logic", errorsBefore);
  endtask

  task automatic addSubTest();
    int         errorsBefore;
    logic [7:0] a;
    logic [7:0] b;
    int         total;
    errorsBefore = errorCount;
    a = 8'($urandom);
    b = 8'($urandom);
    total = int'(a) + int'(b);
    clearMemory();
    loadImm(regA, a);
    loadImm(regB, b);
    aluWithReg(aluAdd, regB);
    loadHl(resultBase);
    putByte(opLdHlA);
    jumpTo(opJpC, 16'h0100);
    markerBranch(16'h0100, resultBase + 16'd1);
    loadImm(regA, a);
    aluWithReg(aluSub, regB);
    loadHl(resultBase + 16'd2);
    putByte(opLdHlA);
    jumpTo(opJpC, 16'h0140);
    markerBranch(16'h0140, resultBase + 16'd3);
    putByte(opHalt);
    expectStore(resultBase, 8'(total % 256));
    if (total > 255)
      expectStore(resultBase + 16'd1, marker);   // Carry out of bit 7
    expectStore(resultBase + 16'd2, a - b);
    if (a < b)
      expectStore(resultBase + 16'd3, marker);   // Borrow
    runProgram();
    compareWrites();
    reportTest("add, subtract and carry", errorsBefore);
  endtask

  task automatic decLoopTest();
    int          errorsBefore;
    logic [7:0]  k;
    logic [15:0] loopAt;
    errorsBefore = errorCount;
    k = 8'(1 + $urandom_range(19));
    clearMemory();
    loadImm(regB, k);
    loadImm(regA, 8'h00);
    loopAt = here;
    stepReg(regA, 1'b0);
    stepReg(regB, 1'b1);
    jumpTo(opJpNz, loopAt);
    loadHl(resultBase);
    putByte(opLdHlA);
    putByte(opHalt);
    expectStore(resultBase, k);
    runProgram();
    compareWrites();
    reportTest("decrement loop", errorsBefore);
  endtask

  task automatic memReadHaltTest();
    int          errorsBefore;
    logic [15:0] p;
    logic [7:0]  v;
    logic [7:0]  w;
    errorsBefore = errorCount;
    p = 16'h4000 | 16'($urandom_range(16'h3FFF));
    v = 8'($urandom);
    w = 8'($urandom);
    clearMemory();
    mem[p] = v;   // Preloaded operand
    loadHl(p);
    putByte(opLdAHl);
    loadImm(regB, w);
    aluWithReg(aluAdd, regB);
    loadHl(resultBase);
    putByte(opLdHlA);
    putByte(opHalt);
    expectStore(resultBase, v + w);
    runProgram();
    repeat (20) @(posedge iClock);
    checkValue("halted", {15'd0, halted}, 16'd1);
    if (lateAccesses != 0)
    begin
      $display("Bus was accessed %0d times after halt", lateAccesses);
      errorCount++;
    end
    compareWrites();
    reportTest("memory read and halt", errorsBefore);
  endtask

  initial
  begin
    rstN <= 1'b0;
    memReadData <= '0;
    errorCount = 0;
    passCount = 0;
    failCount = 0;
    lateAccesses = 0;
    here = '0;
    void'($urandom(32'h2d641140));
    loadStoreTest();
    logicTest();
    addSubTest();
    decLoopTest();
    memReadHaltTest();
    $display("Tests passed: %0d, failed: %0d", passCount, failCount);
    if (failCount == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

//--- vlog.f
cpuPkg.sv
uopIf.sv
regIf.sv
microcodeRom.sv
microSequencer.sv
registerFile.sv
executeUnit.sv
dzCore.sv
tbCore.sv

//--- Makefile
SRCS := $(shell cat vlog.f)

all: run

obj_dir/VtbCore: vlog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tbCore -o VtbCore

run: obj_dir/VtbCore
	./obj_dir/VtbCore | tee sim.log
	grep -q "^Regression passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
